// ==== project.f ====
uart_timing_pkg.sv
uart_frame_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_uart_top.sv

// ==== Makefile ====
# Verilator build and run for the UART testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= No errors

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message appears as a line of its own
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_uart_top.sv ====
// Directed testbench for uart_top at 16 clock cycles per bit with 4-entry queues
// Expected frames and bytes follow the 8N1 rules of start 0, data LSB first and stop 1
module tb_uart_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned CLK_FREQ     = 50_000_000;
  localparam int unsigned BAUD         = 3_125_000;
  localparam int unsigned DEPTH        = 4;
  localparam int          CLK_HALF_NS  = 10;
  localparam int          BIT_CYCLES   = CLK_FREQ / BAUD;
  localparam int          BIT_NS       = BIT_CYCLES * 2 * CLK_HALF_NS;
  localparam int          FRAME_CYCLES = 10 * BIT_CYCLES;
  localparam int          RESET_CYCLES = 16;
  localparam int          CAPTURE_WAIT = 2 * FRAME_CYCLES;
  localparam int          WATCHDOG_NS  = (40 * FRAME_CYCLES + RESET_CYCLES) * 2 * CLK_HALF_NS;

  logic                       clk;
  logic                       rst_ni;
  uart_frame_pkg::uart_byte_t tx_data_i;
  logic                       tx_write_i;
  logic                       tx_full_o;
  uart_frame_pkg::uart_byte_t rx_data_o;
  logic                       rx_read_i;
  logic                       rx_empty_o;
  logic                       frame_err_o;
  logic                       tx_o;
  logic                       rx_i;

  int                         errors;
  int                         err_pulses;
  int                         seed;
  uart_frame_pkg::uart_byte_t rx_expected [$];

  uart_top #(
    .CLK_FREQ (CLK_FREQ),
    .BAUD     (BAUD),
    .DEPTH    (DEPTH)
  ) u_uart_top (
    .clk_i       (clk),
    .rst_ni      (rst_ni),
    .tx_data_i   (tx_data_i),
    .tx_write_i  (tx_write_i),
    .tx_full_o   (tx_full_o),
    .rx_data_o   (rx_data_o),
    .rx_read_i   (rx_read_i),
    .rx_empty_o  (rx_empty_o),
    .frame_err_o (frame_err_o),
    .tx_o        (tx_o),
    .rx_i        (rx_i)
  );

  always #(CLK_HALF_NS) clk = ~clk;

  always @(posedge clk) begin
    if (frame_err_o) err_pulses++;  // One count per high cycle
  end

  function automatic uart_frame_pkg::uart_byte_t next_byte();
    return uart_frame_pkg::uart_byte_t'($random(seed));
  endfunction

  // Line model sending start bit, data LSB first, then the chosen stop level
  task automatic send_frame(input uart_frame_pkg::uart_byte_t data, input logic stop_level,
                            input int bit_cycles);
    logic [9:0] bits;
    bits = {stop_level, data, 1'b0};
    for (int k = 0; k < 10; k++) begin
      @(posedge clk);
      #2 rx_i = bits[k];
      repeat (bit_cycles - 1) @(posedge clk);
    end
    @(posedge clk);
    #2 rx_i = 1'b1;
  endtask

  task automatic send_glitch(input int low_cycles);
    @(posedge clk);
    #2 rx_i = 1'b0;
    repeat (low_cycles - 1) @(posedge clk);
    @(posedge clk);
    #2 rx_i = 1'b1;
  endtask

  // Finds a falling tx_o, then samples every bit at 1/8, 1/2 and 7/8 of its length
  task automatic capture_frame(output uart_frame_pkg::uart_byte_t data, output bit found,
                               input int timeout_cycles);
    logic       last;
    logic [9:0] bits;
    logic       s_early;
    logic       s_mid;
    logic       s_late;
    int         waited;
    found  = 1'b0;
    data   = '0;
    bits   = '0;
    last   = tx_o;
    waited = 0;
    while (!found && waited < timeout_cycles) begin
      @(posedge clk);
      #1;
      if (last && !tx_o) found = 1'b1;
      last = tx_o;
      waited++;
    end
    if (found) begin
      for (int k = 0; k < 10; k++) begin
        #(BIT_NS / 8) s_early = tx_o;
        #(BIT_NS * 3 / 8) s_mid = tx_o;
        #(BIT_NS * 3 / 8) s_late = tx_o;
        if (k < 9) #(BIT_NS / 8);  // Last bit stops early so a following start is seen
        assert (s_early == s_mid && s_mid == s_late) else begin
          errors++;
          $display("error %0t: tx_o bit %0d not stable, samples %b%b%b", $time, k,
                   s_early, s_mid, s_late);
        end
        bits[k] = s_mid;
      end
      assert (bits[0] == 1'b0 && bits[9] == 1'b1) else begin
        errors++;
        $display("error %0t: tx_o start %b stop %b", $time, bits[0], bits[9]);
      end
      data = bits[8:1];
    end
  endtask

  task automatic write_byte(input uart_frame_pkg::uart_byte_t data);
    @(posedge clk);
    #2;
    tx_data_i  = data;
    tx_write_i = 1'b1;
  endtask

  task automatic release_write();
    @(posedge clk);
    #2 tx_write_i = 1'b0;
  endtask

  // Pops every expected byte and checks order, then an empty queue
  task automatic drain_rx();
    uart_frame_pkg::uart_byte_t exp;
    while (rx_expected.size() > 0) begin
      exp = rx_expected.pop_front();
      assert (!rx_empty_o && rx_data_o == exp) else begin
        errors++;
        $display("error %0t: rx_data_o %h empty %b, expected %h", $time, rx_data_o,
                 rx_empty_o, exp);
      end
      @(posedge clk);
      #2 rx_read_i = 1'b1;
      @(posedge clk);
      #2 rx_read_i = 1'b0;
    end
    assert (rx_empty_o) else begin
      errors++;
      $display("error %0t: rx_empty_o low after the last read", $time);
    end
  endtask

  task automatic check_reset_state();
    assert (tx_o && !tx_full_o && rx_empty_o && !frame_err_o) else begin
      errors++;
      $display("error %0t: after reset tx_o %b tx_full_o %b rx_empty_o %b frame_err_o %b",
               $time, tx_o, tx_full_o, rx_empty_o, frame_err_o);
    end
  endtask

  task automatic tx_framing();
    uart_frame_pkg::uart_byte_t sent;
    uart_frame_pkg::uart_byte_t got;
    bit                         found;
    for (int n = 0; n < 3; n++) begin
      sent = next_byte();
      write_byte(sent);
      release_write();
      capture_frame(got, found, CAPTURE_WAIT);
      assert (found && got == sent) else begin
        errors++;
        $display("error %0t: tx frame found %b byte %h, expected %h", $time, found, got, sent);
      end
    end
  endtask

  task automatic rx_in_order();
    uart_frame_pkg::uart_byte_t data;
    for (int n = 0; n < DEPTH; n++) begin
      data = next_byte();
      rx_expected.push_back(data);
      send_frame(data, 1'b1, BIT_CYCLES);
    end
    @(posedge clk);
    #2 drain_rx();
  endtask

  task automatic glitch_and_frame_error();
    int pulses_before;
    pulses_before = err_pulses;
    send_glitch(BIT_CYCLES / 2 - 3);
    repeat (FRAME_CYCLES + BIT_CYCLES) @(posedge clk);  // Long enough for a false frame to end
    #2;
    assert (rx_empty_o && err_pulses == pulses_before) else begin
      errors++;
      $display("error %0t: glitch gave rx_empty_o %b and %0d frame errors", $time,
               rx_empty_o, err_pulses - pulses_before);
    end
    send_frame(next_byte(), 1'b0, BIT_CYCLES);
    repeat (BIT_CYCLES) @(posedge clk);  // Let the low stop bit clear
    #2;
    assert (rx_empty_o && err_pulses == pulses_before + 1) else begin
      errors++;
      $display("error %0t: bad stop gave rx_empty_o %b and %0d frame errors", $time,
               rx_empty_o, err_pulses - pulses_before);
    end
  endtask

  task automatic tx_back_pressure();
    uart_frame_pkg::uart_byte_t sent [6];
    uart_frame_pkg::uart_byte_t got [5];
    uart_frame_pkg::uart_byte_t extra;
    bit                         found [5];
    bit                         extra_found;
    for (int n = 0; n < 6; n++) sent[n] = next_byte();
    fork
      begin
        for (int n = 0; n < 6; n++) write_byte(sent[n]);
        release_write();
        assert (tx_full_o) else begin
          errors++;
          $display("error %0t: tx_full_o low after 6 writes", $time);
        end
      end
      begin
        for (int n = 0; n < 5; n++) capture_frame(got[n], found[n], CAPTURE_WAIT);
      end
    join
    for (int n = 0; n < 5; n++) begin
      assert (found[n] && got[n] == sent[n]) else begin
        errors++;
        $display("error %0t: queued frame %0d found %b byte %h, expected %h", $time, n,
                 found[n], got[n], sent[n]);
      end
    end
    capture_frame(extra, extra_found, CAPTURE_WAIT);
    assert (!extra_found) else begin
      errors++;
      $display("The sixth byte was sent although the transmit queue was full");
    end
  endtask

  task automatic rx_overflow();
    uart_frame_pkg::uart_byte_t data;
    for (int n = 0; n < 6; n++) begin
      data = next_byte();
      if (n < DEPTH) rx_expected.push_back(data);  // Later bytes find the queue full
      send_frame(data, 1'b1, BIT_CYCLES);
    end
    @(posedge clk);
    #2 drain_rx();
  endtask

  initial begin
    clk        = 1'b0;
    rst_ni     = 1'b0;
    tx_data_i  = '0;
    tx_write_i = 1'b0;
    rx_read_i  = 1'b0;
    rx_i       = 1'b1;
    errors     = 0;
    err_pulses = 0;
    seed       = 96;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 rst_ni = 1'b1;

    check_reset_state();
    tx_framing();
    rx_in_order();
    glitch_and_frame_error();
    tx_back_pressure();
    rx_overflow();

    $display("Summary: %0d errors", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== uart_top.sv ====
// UART with transmit and receive byte queues and plain strobe host access
// CLK_FREQ must be a whole multiple of BAUD; DEPTH is a power of two of at least 2
module uart_top #(
  parameter int unsigned CLK_FREQ = 50_000_000,
  parameter int unsigned BAUD     = 115_200,
  parameter int unsigned DEPTH    = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Host side
  input  uart_frame_pkg::uart_byte_t tx_data_i,
  input  logic                       tx_write_i,
  output logic                       tx_full_o,
  output uart_frame_pkg::uart_byte_t rx_data_o,
  input  logic                       rx_read_i,
  output logic                       rx_empty_o,
  output logic                       frame_err_o,

  // Serial line
  output logic                       tx_o,
  input  logic                       rx_i
);

  localparam int unsigned CYCLES_PER_BIT = CLK_FREQ / BAUD;

  uart_frame_pkg::uart_byte_t tx_fifo_data;
  logic                       tx_fifo_empty;
  logic                       tx_fifo_pop;

  uart_frame_pkg::uart_byte_t rx_push_data;
  logic                       rx_push;
  logic                       rx_fifo_full;

  uart_fifo #(
    .DEPTH (DEPTH)
  ) u_tx_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (tx_write_i),
    .data_i  (tx_data_i),
    .pop_i   (tx_fifo_pop),
    .data_o  (tx_fifo_data),
    .full_o  (tx_full_o),
    .empty_o (tx_fifo_empty)
  );

  uart_tx #(
    .CYCLES_PER_BIT (CYCLES_PER_BIT)
  ) u_tx (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fifo_data_i  (tx_fifo_data),
    .fifo_empty_i (tx_fifo_empty),
    .fifo_pop_o   (tx_fifo_pop),
    .tx_o         (tx_o)
  );

  uart_rx #(
    .CYCLES_PER_BIT (CYCLES_PER_BIT)
  ) u_rx (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rx_i        (rx_i),
    .fifo_full_i (rx_fifo_full),
    .fifo_push_o (rx_push),
    .fifo_data_o (rx_push_data),
    .frame_err_o (frame_err_o)
  );

  uart_fifo #(
    .DEPTH (DEPTH)
  ) u_rx_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (rx_push),
    .data_i  (rx_push_data),
    .pop_i   (rx_read_i),
    .data_o  (rx_data_o),
    .full_o  (rx_fifo_full),
    .empty_o (rx_empty_o)
  );

endmodule

// ==== uart_rx.sv ====
// 8N1 deserializer. Start bit is checked after half a bit period, then one sample per period
// A byte that arrives while the queue is full is lost. CYCLES_PER_BIT must be at least 2
module uart_rx #(
  parameter int unsigned CYCLES_PER_BIT = 16
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       rx_i,

  input  logic                       fifo_full_i,
  output logic                       fifo_push_o,
  output uart_frame_pkg::uart_byte_t fifo_data_o,

  output logic                       frame_err_o
);

  localparam uart_timing_pkg::cycle_cnt_t BIT_LAST =
    uart_timing_pkg::cycle_cnt_t'(CYCLES_PER_BIT - 1);
  localparam uart_timing_pkg::cycle_cnt_t HALF_LAST =
    uart_timing_pkg::cycle_cnt_t'(CYCLES_PER_BIT / 2 - 1);
  localparam uart_timing_pkg::bit_idx_t LAST_DATA_POS =
    uart_timing_pkg::bit_idx_t'(uart_frame_pkg::STOP_IDX - 1);

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } rx_state_e;

  logic [1:0]                  sync_q;
  logic                        rx_s;
  rx_state_e                   state_q;
  uart_timing_pkg::cycle_cnt_t cnt_q;
  uart_timing_pkg::bit_idx_t   idx_q;
  uart_frame_pkg::uart_byte_t  data_q;
  logic                        stop_sample;

  assign rx_s = sync_q[1];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sync_q <= {2{uart_frame_pkg::LINE_IDLE}};  // No false start out of reset
    end else begin
      sync_q <= {sync_q[0], rx_i};
    end
  end

  assign stop_sample = (state_q == STOP) && (cnt_q == BIT_LAST);

  assign fifo_push_o = stop_sample && (rx_s == uart_frame_pkg::LINE_IDLE) && !fifo_full_i;
  assign fifo_data_o = data_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      cnt_q       <= '0;
      idx_q       <= '0;
      frame_err_o <= 1'b0;
    end else begin
      frame_err_o <= stop_sample && (rx_s != uart_frame_pkg::LINE_IDLE);
      cnt_q       <= cnt_q + 1'b1;
      case (state_q)
        IDLE: begin
          cnt_q <= '0;
          if (rx_s != uart_frame_pkg::LINE_IDLE) begin
            state_q <= START;
          end
        end
        START: begin
          if (cnt_q == HALF_LAST) begin
            cnt_q <= '0;
            idx_q <= uart_timing_pkg::bit_idx_t'(1);  // First data bit position
            // Line back high at mid start bit means a glitch
            state_q <= (rx_s == uart_frame_pkg::LINE_IDLE) ? IDLE : DATA;
          end
        end
        DATA: begin
          if (cnt_q == BIT_LAST) begin
            cnt_q <= '0;
            idx_q <= idx_q + 1'b1;
            if (idx_q == LAST_DATA_POS) begin
              state_q <= STOP;
            end
          end
        end
        STOP: begin
          if (stop_sample) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == DATA) && (cnt_q == BIT_LAST)) begin
      data_q <= {rx_s, data_q[uart_frame_pkg::DATA_BITS-1:1]};  // LSB first
    end
  end

endmodule

// ==== uart_tx.sv ====
// 8N1 serializer. Pops a byte when idle and drives the start bit two cycles after the write
// Frames run back to back while the queue has data. CYCLES_PER_BIT must be at least 2
module uart_tx #(
  parameter int unsigned CYCLES_PER_BIT = 16
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  uart_frame_pkg::uart_byte_t fifo_data_i,
  input  logic                       fifo_empty_i,
  output logic                       fifo_pop_o,

  output logic                       tx_o
);

  localparam uart_timing_pkg::cycle_cnt_t BIT_LAST =
    uart_timing_pkg::cycle_cnt_t'(CYCLES_PER_BIT - 1);
  localparam uart_timing_pkg::bit_idx_t STOP_POS =
    uart_timing_pkg::bit_idx_t'(uart_frame_pkg::STOP_IDX);

  typedef enum logic {
    IDLE,
    SEND
  } tx_state_e;

  tx_state_e                   state_q;
  uart_timing_pkg::cycle_cnt_t cnt_q;
  uart_timing_pkg::bit_idx_t   idx_q;
  logic [uart_frame_pkg::DATA_BITS+1:0] frame_q;  // Stop, data, start; LSB goes out first

  logic bit_end;
  logic frame_done;
  logic load;

  assign bit_end    = (state_q == SEND) && (cnt_q == BIT_LAST);
  assign frame_done = bit_end && (idx_q == STOP_POS);

  // Next byte is taken when idle or right at the end of the stop bit
  assign load       = !fifo_empty_i && ((state_q == IDLE) || frame_done);
  assign fifo_pop_o = load;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      idx_q   <= '0;
      tx_o    <= uart_frame_pkg::LINE_IDLE;
    end else begin
      // Line follows the frame register one cycle late
      tx_o <= (state_q == SEND) ? frame_q[0] : uart_frame_pkg::LINE_IDLE;

      if (load) begin
        state_q <= SEND;
        cnt_q   <= '0;
        idx_q   <= '0;
      end else if (frame_done) begin
        state_q <= IDLE;
      end else if (bit_end) begin
        cnt_q <= '0;
        idx_q <= idx_q + 1'b1;
      end else if (state_q == SEND) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      frame_q <= {uart_frame_pkg::LINE_IDLE, fifo_data_i, ~uart_frame_pkg::LINE_IDLE};
    end else if (bit_end) begin
      frame_q <= {uart_frame_pkg::LINE_IDLE, frame_q[uart_frame_pkg::DATA_BITS+1:1]};
    end
  end

endmodule

// ==== uart_fifo.sv ====
// Byte queue with first-word fall-through; data_o is valid while empty_o is low
// DEPTH must be a power of two of at least 2. Push when full and pop when empty are dropped
module uart_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       push_i,
  input  uart_frame_pkg::uart_byte_t data_i,

  input  logic                       pop_i,
  output uart_frame_pkg::uart_byte_t data_o,

  output logic                       full_o,
  output logic                       empty_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  uart_frame_pkg::uart_byte_t mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign data_o = mem_q[rd_ptr_q];  // Head shown without a read

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at DEPTH
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== uart_frame_pkg.sv ====
// 8N1 frame layout with start bit low, data bits LSB first and one stop bit high
// Parity and other frame lengths are not supported
package uart_frame_pkg;

  typedef logic [7:0] uart_byte_t;

  localparam int unsigned DATA_BITS = 8;
  localparam int unsigned STOP_IDX  = DATA_BITS + 1;  // Start bit sits at index 0

  // The idle line sits at the stop bit level
  localparam logic LINE_IDLE = 1'b1;

endpackage

// ==== uart_timing_pkg.sv ====
// Bit-timing types shared by the serializer and deserializer
// A bit period is limited to 65535 clock cycles
package uart_timing_pkg;

  // Cycle count within one bit period
  typedef logic [15:0] cycle_cnt_t;

  // Position within a frame from the start bit at 0 to the stop bit at 9
  typedef logic [3:0] bit_idx_t;

endpackage
